//--- hdl/core_pkg.sv
// Bus, setting and ADC types, boot state enum, address map and register offsets
`default_nettype none

package core_pkg;

   ////////////////////////////////////////////////////////////
   // Wishbone request and response
   typedef struct packed {
      logic [15:0] adr;                  // Byte address
      logic [31:0] dat;                  // Write data
      logic [3:0]  sel;                  // Byte lanes
      logic        we;
      logic        cyc;
      logic        stb;
   } wb_req_t;

   typedef struct packed {
      logic [31:0] dat;                  // Read data
      logic        ack;
   } wb_rsp_t;

   // One write on the settings bus
   typedef struct packed {
      logic        stb;                  // Single-cycle strobe
      logic [7:0]  addr;                 // Register number
      logic [31:0] data;
   } setting_t;

   // ADC sample pair
   typedef struct packed {
      logic [11:0] a;
      logic [11:0] b;
   } adc_pair_t;

   typedef enum logic {
      BOOT_WAIT = 1'b0,                  // Waiting for the bootloader
      BOOT_DONE = 1'b1
   } boot_state_e;

   ////////////////////////////////////////////////////////////
   // High-byte decode of the slaves
   localparam logic [7:0] RB_DECODE_ADDR  = 8'h5C;   // Readback, 1K
   localparam logic [7:0] RB_DECODE_MASK  = 8'hFC;
   localparam logic [7:0] SET_DECODE_ADDR = 8'h70;   // Settings, 4K window
   localparam logic [7:0] SET_DECODE_MASK = 8'hF0;

   // Setting register map
   localparam logic [7:0] SR_MISC  = 8'd0;
   localparam logic [7:0] SR_DIVSW = 8'd180;

   localparam logic [7:0] MISC_CLK     = 8'd0;
   localparam logic [7:0] MISC_LED     = 8'd3;
   localparam logic [7:0] MISC_PHY     = 8'd4;
   localparam logic [7:0] MISC_BLDR    = 8'd5;
   localparam logic [7:0] MISC_LED_SRC = 8'd6;

   localparam logic [7:0] LED_SRC_RESET = 8'h1E;     // Run LEDs under hardware control

   // Bump when the register map changes
   localparam logic [31:0] COMPAT_NUM = {16'd8, 16'd2};

endpackage

`default_nettype wire

//--- hdl/wb_decoder.sv
// Single-master Wishbone decoder for the readback and settings slaves
`default_nettype none
`timescale 1ns/1ps

module wb_decoder
   import core_pkg::*;
#(
   parameter logic [7:0] RB_ADDR  = RB_DECODE_ADDR,
   parameter logic [7:0] RB_MASK  = RB_DECODE_MASK,
   parameter logic [7:0] SET_ADDR = SET_DECODE_ADDR,
   parameter logic [7:0] SET_MASK = SET_DECODE_MASK
) (
   input  wire          wb_clk,
   input  wire          wb_rst_i,
   input  wire wb_req_t m_req_i,
   output wb_rsp_t      m_rsp_o,
   output wb_req_t      rb_req_o,
   input  wire wb_rsp_t rb_rsp_i,
   output wb_req_t      set_req_o,
   input  wire wb_rsp_t set_rsp_i
);

   logic rb_hit;
   logic set_hit;
   logic rb_sel_q;
   logic set_sel_q;

   // Masked compare on the high address byte
   function automatic logic addr_match(input logic [7:0] hi,
                                       input logic [7:0] base,
                                       input logic [7:0] mask);
      return (hi & mask) == (base & mask);
   endfunction

   assign rb_hit  = addr_match(m_req_i.adr[15:8], RB_ADDR, RB_MASK);
   assign set_hit = addr_match(m_req_i.adr[15:8], SET_ADDR, SET_MASK);

   ////////////////////////////////////////////////////////////
   // Request steering
   always_comb begin
      rb_req_o      = m_req_i;
      rb_req_o.stb  = m_req_i.stb & rb_hit;     // Other slaves see no strobe
      set_req_o     = m_req_i;
      set_req_o.stb = m_req_i.stb & set_hit;
   end

   // Both slaves answer one cycle after the strobe, so the
   // response is routed from the slave addressed on the cycle before
   always_ff @(posedge wb_clk) begin
      if (wb_rst_i) begin
         rb_sel_q  <= 1'b0;
         set_sel_q <= 1'b0;
      end else begin
         rb_sel_q  <= m_req_i.cyc & m_req_i.stb & rb_hit;
         set_sel_q <= m_req_i.cyc & m_req_i.stb & set_hit;
      end
   end

   ////////////////////////////////////////////////////////////
   // Response mux
   always_comb begin
      m_rsp_o = '0;                              // Unmapped: no ack
      if (rb_sel_q) begin
         m_rsp_o = rb_rsp_i;
      end else if (set_sel_q) begin
         m_rsp_o = set_rsp_i;
      end
   end

endmodule

`default_nettype wire

//--- hdl/settings_bus.sv
// Wishbone slave that turns bus writes into settings-bus strobes
`default_nettype none
`timescale 1ns/1ps

module settings_bus
   import core_pkg::*;
(
   input  wire          wb_clk,
   input  wire          wb_rst_i,
   input  wire wb_req_t req_i,
   output wb_rsp_t      rsp_o,
   output setting_t     set_o
);

   logic        ack_q;
   logic        stb_q;
   logic [7:0]  addr_q;
   logic [31:0] data_q;
   logic        access;

   assign access = req_i.cyc & req_i.stb & ~ack_q;   // New transfer only

   always_ff @(posedge wb_clk) begin
      if (wb_rst_i) begin
         ack_q <= 1'b0;
         stb_q <= 1'b0;
      end else begin
         ack_q <= access;
         stb_q <= access & req_i.we;
      end
   end

   // Word address of the register
   always_ff @(posedge wb_clk) begin
      if (access & req_i.we) begin
         addr_q <= req_i.adr[9:2];
         data_q <= req_i.dat;
      end
   end

   assign rsp_o = '{dat: 32'd0, ack: ack_q};         // Write-only, reads give zero
   assign set_o = '{stb: stb_q, addr: addr_q, data: data_q};

endmodule

`default_nettype wire

//--- hdl/misc_regs.sv
// Miscellaneous setting registers: clock control, PHY reset, boot flag, diversity and LEDs
`default_nettype none
`timescale 1ns/1ps

module misc_regs
   import core_pkg::*;
#(
   parameter logic [7:0] MISC_BASE    = SR_MISC,
   parameter logic [7:0] DIVSW_BASE   = SR_DIVSW,
   parameter logic [7:0] LED_SRC_INIT = LED_SRC_RESET
) (
   input  wire           wb_clk,
   input  wire           wb_rst_i,
   input  wire setting_t set_i,
   input  wire [3:0]     run_i,
   output logic          bldr_done_o,
   output logic [7:0]    leds_o,
   output logic          clock_ready_o,
   output logic [1:0]    clk_en_o,
   output logic [1:0]    clk_sel_o,
   output logic [1:0]    lms_res_o,
   output logic          phy_reset_n_o,
   output logic [1:0]    div_sw_o
);

   localparam logic [7:0] ADDR_CLK     = MISC_BASE + MISC_CLK;
   localparam logic [7:0] ADDR_LED     = MISC_BASE + MISC_LED;
   localparam logic [7:0] ADDR_PHY     = MISC_BASE + MISC_PHY;
   localparam logic [7:0] ADDR_BLDR    = MISC_BASE + MISC_BLDR;
   localparam logic [7:0] ADDR_LED_SRC = MISC_BASE + MISC_LED_SRC;
   localparam logic [7:0] ADDR_DIVSW0  = DIVSW_BASE;
   localparam logic [7:0] ADDR_DIVSW1  = DIVSW_BASE + 8'd1;

   logic [7:0] clock_q;                   // Clock generator and LMS control
   logic [7:0] led_sw_q;                  // Software LED value
   logic [7:0] led_src_q;                 // 1 = hardware, 0 = software
   logic       phy_rst_q;
   logic       bldr_q;
   logic [1:0] div_sw_q;
   logic [7:0] led_hw;

   ////////////////////////////////////////////////////////////
   // Register writes
   always_ff @(posedge wb_clk) begin
      if (wb_rst_i) begin
         clock_q   <= 8'h00;
         led_sw_q  <= 8'h00;
         led_src_q <= LED_SRC_INIT;
         phy_rst_q <= 1'b0;
         bldr_q    <= 1'b0;
         div_sw_q  <= 2'b11;              // Both switches on
      end else if (set_i.stb) begin
         case (set_i.addr)
            ADDR_CLK:     clock_q   <= set_i.data[7:0];
            ADDR_LED:     led_sw_q  <= set_i.data[7:0];
            ADDR_PHY:     phy_rst_q <= set_i.data[0];
            ADDR_BLDR:    bldr_q    <= set_i.data[0];
            ADDR_LED_SRC: led_src_q <= set_i.data[7:0];
            ADDR_DIVSW0:  div_sw_q[0] <= set_i.data[0];
            ADDR_DIVSW1:  div_sw_q[1] <= set_i.data[0];
            default: begin
            end
         endcase
      end
   end

   ////////////////////////////////////////////////////////////
   // Output fields
   assign clock_ready_o = clock_q[4];
   assign clk_en_o      = clock_q[3:2];
   assign clk_sel_o     = clock_q[1:0];
   assign lms_res_o     = clock_q[6:5];

   assign phy_reset_n_o = ~phy_rst_q;     // Active low at the pin
   assign bldr_done_o   = bldr_q;
   assign div_sw_o      = div_sw_q;

   // Run flags sit on LEDs 4..1
   assign led_hw = {3'b000, run_i, 1'b0};

   // Per-bit choice between hardware and software value
   assign leds_o = (led_src_q & led_hw) | (~led_src_q & led_sw_q);

endmodule

`default_nettype wire

//--- hdl/boot_ctrl.sv
// Boot reset controller that pulses the bus reset once the bootloader is done
`default_nettype none
`timescale 1ns/1ps

module boot_ctrl
   import core_pkg::*;
(
   input  wire  wb_clk,
   input  wire  por_rst,
   input  wire  bldr_done_i,
   output logic wb_rst_o
);

   boot_state_e state_q;

   always_ff @(posedge wb_clk) begin
      if (por_rst) begin
         state_q  <= BOOT_WAIT;
         wb_rst_o <= 1'b1;                // Bus held in reset with POR
      end else begin
         case (state_q)
            BOOT_WAIT: begin
               wb_rst_o <= 1'b0;
               if (bldr_done_i) begin     // Flag set by the bootloader
                  state_q  <= BOOT_DONE;
                  wb_rst_o <= 1'b1;       // One-cycle bus reset
               end
            end

            // Stays here until the next power-on reset
            BOOT_DONE: begin
               wb_rst_o <= 1'b0;
            end

            default: begin
               state_q  <= BOOT_WAIT;
               wb_rst_o <= 1'b1;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

//--- hdl/readback_mux.sv
// Registered readback slave with sixteen status words
`default_nettype none
`timescale 1ns/1ps

module readback_mux
   import core_pkg::*;
#(
   parameter logic [31:0] COMPAT = COMPAT_NUM
) (
   input  wire            wb_clk,
   input  wire            wb_rst_i,
   input  wire wb_req_t   req_i,
   output wb_rsp_t        rsp_o,
   input  wire adc_pair_t adc0_i,
   input  wire adc_pair_t adc1_i,
   input  wire [1:0]      aux_ld_i,
   input  wire            button_i,
   input  wire            clk_status_i
);

   logic        ack_q;
   logic [31:0] dat_q;
   logic [31:0] word;
   logic        access;

   assign access = req_i.cyc & req_i.stb & ~ack_q;

   ////////////////////////////////////////////////////////////
   // Word select on address bits 5..2
   always_comb begin
      case (req_i.adr[5:2])
         4'd6:  word = {adc0_i.a, 4'b0000, adc0_i.b, 4'b0000};
         4'd7:  word = {adc1_i.a, 4'b0000, adc1_i.b, 4'b0000};
         4'd12: word = COMPAT;
         4'd13: word = {16'h0000, aux_ld_i[1], aux_ld_i[0], button_i,
                        1'b0, clk_status_i, 11'd0};      // Status word
         default: word = 32'd0;
      endcase
   end

   always_ff @(posedge wb_clk) begin
      if (wb_rst_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= access;
      end
   end

   // Snapshot taken with the strobe
   always_ff @(posedge wb_clk) begin
      if (access) begin
         dat_q <= word;
      end
   end

   assign rsp_o = '{dat: dat_q, ack: ack_q};

endmodule

`default_nettype wire

//--- hdl/umtrx_ctrl_core.sv
// Control core top level: bus decoder, settings bridge, setting registers, readback, boot reset
`default_nettype none
`timescale 1ns/1ps

module umtrx_ctrl_core
   import core_pkg::*;
(
   input  wire            wb_clk,
   input  wire            por_rst,

   // Bus master port
   input  wire wb_req_t   wb_m_i,
   output wb_rsp_t        wb_m_o,

   // Status inputs
   input  wire adc_pair_t adc0_i,
   input  wire adc_pair_t adc1_i,
   input  wire [3:0]      run_i,            // Radio run flags for the LEDs
   input  wire [1:0]      aux_ld_i,
   input  wire            button_i,
   input  wire            clk_status_i,

   // Control outputs
   output logic [7:0]     leds_o,
   output logic           clock_ready_o,
   output logic [1:0]     clk_en_o,
   output logic [1:0]     clk_sel_o,
   output logic [1:0]     lms_res_o,
   output logic           phy_reset_n_o,
   output logic [1:0]     div_sw_o
);

   logic     wb_rst;
   logic     bldr_done;
   wb_req_t  rb_req;
   wb_rsp_t  rb_rsp;
   wb_req_t  set_req;
   wb_rsp_t  set_rsp;
   setting_t set_bus;

   ////////////////////////////////////////////////////////////
   // Reset
   boot_ctrl u_boot_ctrl (
      .wb_clk      (wb_clk),
      .por_rst     (por_rst),
      .bldr_done_i (bldr_done),
      .wb_rst_o    (wb_rst)
   );

   ////////////////////////////////////////////////////////////
   // Interconnect
   wb_decoder #(
      .RB_ADDR  (RB_DECODE_ADDR),
      .RB_MASK  (RB_DECODE_MASK),
      .SET_ADDR (SET_DECODE_ADDR),
      .SET_MASK (SET_DECODE_MASK)
   ) u_wb_decoder (
      .wb_clk    (wb_clk),
      .wb_rst_i  (wb_rst),
      .m_req_i   (wb_m_i),
      .m_rsp_o   (wb_m_o),
      .rb_req_o  (rb_req),
      .rb_rsp_i  (rb_rsp),
      .set_req_o (set_req),
      .set_rsp_i (set_rsp)
   );

   // Readback slave
   readback_mux #(
      .COMPAT (COMPAT_NUM)
   ) u_readback_mux (
      .wb_clk       (wb_clk),
      .wb_rst_i     (wb_rst),
      .req_i        (rb_req),
      .rsp_o        (rb_rsp),
      .adc0_i       (adc0_i),
      .adc1_i       (adc1_i),
      .aux_ld_i     (aux_ld_i),
      .button_i     (button_i),
      .clk_status_i (clk_status_i)
   );

   // Settings slave
   settings_bus u_settings_bus (
      .wb_clk   (wb_clk),
      .wb_rst_i (wb_rst),
      .req_i    (set_req),
      .rsp_o    (set_rsp),
      .set_o    (set_bus)
   );

   ////////////////////////////////////////////////////////////
   // Setting registers
   misc_regs #(
      .MISC_BASE    (SR_MISC),
      .DIVSW_BASE   (SR_DIVSW),
      .LED_SRC_INIT (LED_SRC_RESET)
   ) u_misc_regs (
      .wb_clk        (wb_clk),
      .wb_rst_i      (wb_rst),
      .set_i         (set_bus),
      .run_i         (run_i),
      .bldr_done_o   (bldr_done),
      .leds_o        (leds_o),
      .clock_ready_o (clock_ready_o),
      .clk_en_o      (clk_en_o),
      .clk_sel_o     (clk_sel_o),
      .lms_res_o     (lms_res_o),
      .phy_reset_n_o (phy_reset_n_o),
      .div_sw_o      (div_sw_o)
   );

endmodule

`default_nettype wire

//--- tests/tb_ctrl_core.sv
// Table-driven testbench with bus master tasks, register model and output checks
`default_nettype none
`timescale 1ns/1ps

module tb_ctrl_core
   import core_pkg::*;
();

   localparam int          CLK_HALF    = 4;          // 8 ns period
   localparam int          ACK_TIMEOUT = 16;         // Cycles
   localparam logic [15:0] SET_BASE    = 16'h7000;
   localparam logic [15:0] RB_BASE     = 16'h5C00;

   typedef enum logic [1:0] {
      OP_WRITE,
      OP_READ,                                       // Read and compare
      OP_NOACK                                       // Access expected to time out
   } op_e;

   typedef struct packed {
      op_e         op;
      logic [15:0] adr;
      logic [31:0] dat;
      logic [31:0] exp;
   } step_t;

   logic       wb_clk;
   logic       por_rst;
   wb_req_t    wb_m;
   wb_rsp_t    wb_s;
   adc_pair_t  adc0;
   adc_pair_t  adc1;
   logic [3:0] run;
   logic [1:0] aux_ld;
   logic       button;
   logic       clk_status;
   logic [7:0] leds;
   logic       clock_ready;
   logic [1:0] clk_en;
   logic [1:0] clk_sel;
   logic [1:0] lms_res;
   logic       phy_reset_n;
   logic [1:0] div_sw;

   step_t steps[$];
   int    errors;
   int    checks;
   int    tests;

   // Expected register contents
   logic [7:0] m_clock;
   logic [7:0] m_led_sw;
   logic [7:0] m_led_src;
   logic       m_phy;
   logic [1:0] m_div;

   umtrx_ctrl_core DUT (
      .wb_clk        (wb_clk),
      .por_rst       (por_rst),
      .wb_m_i        (wb_m),
      .wb_m_o        (wb_s),
      .adc0_i        (adc0),
      .adc1_i        (adc1),
      .run_i         (run),
      .aux_ld_i      (aux_ld),
      .button_i      (button),
      .clk_status_i  (clk_status),
      .leds_o        (leds),
      .clock_ready_o (clock_ready),
      .clk_en_o      (clk_en),
      .clk_sel_o     (clk_sel),
      .lms_res_o     (lms_res),
      .phy_reset_n_o (phy_reset_n),
      .div_sw_o      (div_sw)
   );

   initial begin
      wb_clk = 1'b0;
      forever #CLK_HALF wb_clk = ~wb_clk;
   end

   ////////////////////////////////////////////////////////////
   // Address helpers and register model
   function automatic logic [15:0] set_addr(input int unsigned reg_num);
      return SET_BASE + 16'(reg_num * 4);
   endfunction

   function automatic logic [15:0] rb_addr(input int unsigned word_num);
      return RB_BASE + 16'(word_num * 4);
   endfunction

   // Source bit 1 picks the hardware bit, 0 the software bit
   function automatic logic [7:0] led_mix(input logic [7:0] src, input logic [7:0] sw,
                                          input logic [3:0] run_flags);
      logic [7:0] hw;
      logic [7:0] mix;
      int         b;
      hw = {3'b000, run_flags, 1'b0};
      for (b = 0; b < 8; b++) begin
         mix[b] = src[b] ? hw[b] : sw[b];
      end
      return mix;
   endfunction

   function automatic void model_reset();
      m_clock   = 8'h00;
      m_led_sw  = 8'h00;
      m_led_src = 8'h1E;
      m_phy     = 1'b0;
      m_div     = 2'b11;
   endfunction

   function automatic void model_write(input logic [7:0] reg_num, input logic [31:0] data);
      case (reg_num)
         8'd0:    m_clock   = data[7:0];
         8'd3:    m_led_sw  = data[7:0];
         8'd4:    m_phy     = data[0];
         8'd6:    m_led_src = data[7:0];
         8'd180:  m_div[0]  = data[0];
         8'd181:  m_div[1]  = data[0];
         default: m_clock   = m_clock;       // Bootloader flag has no output
      endcase
   endfunction

   function automatic void add_step(input op_e op, input logic [15:0] adr,
                                    input logic [31:0] dat, input logic [31:0] exp);
      step_t s;
      s.op  = op;
      s.adr = adr;
      s.dat = dat;
      s.exp = exp;
      steps.push_back(s);
   endfunction

   ////////////////////////////////////////////////////////////
   // Checking
   task automatic check_val(input string what, input logic [31:0] got,
                            input logic [31:0] exp);
      checks++;
      assert (got === exp) else begin
         $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
         errors++;
      end
   endtask

   task automatic check_outputs();
      check_val("clock_ready", clock_ready, m_clock[4]);
      check_val("clk_en", clk_en, m_clock[3:2]);
      check_val("clk_sel", clk_sel, m_clock[1:0]);
      check_val("lms_res", lms_res, m_clock[6:5]);
      check_val("phy_reset_n", phy_reset_n, !m_phy);
      check_val("div_sw", div_sw, m_div);
      check_val("leds", leds, led_mix(m_led_src, m_led_sw, run));
   endtask

   task automatic end_test(input string name, input int err_before);
      tests++;
      $display("Test %0d %s: %s", tests, name, (errors == err_before) ? "pass" : "fail");
   endtask

   ////////////////////////////////////////////////////////////
   // Bus master
   task automatic bus_access(input logic we, input logic [15:0] adr, input logic [31:0] wdat,
                             output logic [31:0] rdat, output logic acked);
      wb_req_t r;
      int      n;
      r     = '0;
      r.adr = adr;
      r.dat = wdat;
      r.sel = 4'hF;
      r.we  = we;
      r.cyc = 1'b1;
      r.stb = 1'b1;
      rdat  = '0;
      acked = 1'b0;
      @(posedge wb_clk);
      wb_m <= r;
      for (n = 0; n < ACK_TIMEOUT && !acked; n++) begin
         @(negedge wb_clk);
         if (wb_s.ack) begin
            acked = 1'b1;
            rdat  = wb_s.dat;
         end
      end
      @(posedge wb_clk);
      wb_m <= '0;                                     // Strobe drops for a cycle at least
   endtask

   task automatic run_steps();
      step_t       s;
      logic [31:0] rdat;
      logic        acked;
      while (steps.size() > 0) begin
         s = steps.pop_front();
         bus_access(s.op == OP_WRITE, s.adr, s.dat, rdat, acked);
         checks++;
         case (s.op)
            OP_WRITE: begin
               assert (acked) else begin
                  $display("Write to address %h was never acknowledged", s.adr);
                  errors++;
               end
               if (s.adr[15:12] == SET_BASE[15:12]) begin
                  model_write(s.adr[9:2], s.dat);
               end
            end
            OP_READ: begin
               assert (acked) else begin
                  $display("Read from address %h was never acknowledged", s.adr);
                  errors++;
               end
               check_val($sformatf("read data at %h", s.adr), rdat, s.exp);
            end
            default: begin
               assert (!acked) else begin
                  $display("Unmapped address %h was acknowledged", s.adr);
                  errors++;
               end
               if (!acked) begin
                  $display("Access at %h got no acknowledge in %0d cycles, as expected",
                           s.adr, ACK_TIMEOUT);
               end
            end
         endcase
      end
      @(negedge wb_clk);                              // Last write has taken effect
   endtask

   ////////////////////////////////////////////////////////////
   // Stimulus for the status inputs
   task automatic drive_status();
      @(posedge wb_clk);
      adc0       <= adc_pair_t'($urandom);
      adc1       <= adc_pair_t'($urandom);
      aux_ld     <= 2'($urandom);
      button     <= 1'($urandom);
      clk_status <= 1'($urandom);
      @(negedge wb_clk);
   endtask

   task automatic drive_run();
      @(posedge wb_clk);
      run <= 4'($urandom);
      @(negedge wb_clk);
   endtask

   task automatic wait_bus_reset(output logic seen);
      int n;
      seen = 1'b0;
      for (n = 0; n < ACK_TIMEOUT && !seen; n++) begin
         @(negedge wb_clk);
         if (div_sw === 2'b11 && phy_reset_n === 1'b1) begin
            seen = 1'b1;
         end
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Main sequence
   initial begin
      int          err_before;
      int          i;
      logic [31:0] val;
      logic        seen;

      errors = 0;
      checks = 0;
      tests  = 0;
      void'($urandom(32'h281d));
      por_rst    = 1'b1;
      wb_m       = '0;
      adc0       = '0;
      adc1       = '0;
      run        = '0;
      aux_ld     = '0;
      button     = 1'b0;
      clk_status = 1'b0;
      model_reset();

      repeat (3) @(posedge wb_clk);
      por_rst <= 1'b0;
      drive_run();                                    // Bus reset is released by now

      // Reset values
      err_before = errors;
      check_outputs();
      end_test("reset values", err_before);

      // Clock, PHY and diversity registers
      err_before = errors;
      val = $urandom;
      add_step(OP_WRITE, set_addr(0), val & 32'hFF, '0);
      add_step(OP_WRITE, set_addr(4), 32'd1, '0);
      add_step(OP_WRITE, set_addr(180), 32'd0, '0);
      add_step(OP_WRITE, set_addr(181), 32'd0, '0);
      run_steps();
      check_outputs();
      end_test("clock register write", err_before);

      // LED source and value with several run patterns
      err_before = errors;
      add_step(OP_WRITE, set_addr(6), $urandom & 32'hFF, '0);
      add_step(OP_WRITE, set_addr(3), $urandom & 32'hFF, '0);
      run_steps();
      for (i = 0; i < 4; i++) begin
         drive_run();
         check_outputs();
      end
      end_test("LED mix", err_before);

      // Readback words
      err_before = errors;
      drive_status();
      add_step(OP_READ, rb_addr(6), '0, {adc0.a, 4'h0, adc0.b, 4'h0});
      add_step(OP_READ, rb_addr(7), '0, {adc1.a, 4'h0, adc1.b, 4'h0});
      add_step(OP_READ, rb_addr(12), '0, 32'h0008_0002);
      add_step(OP_READ, rb_addr(13), '0,
               {16'h0000, aux_ld[1], aux_ld[0], button, 1'b0, clk_status, 11'd0});
      add_step(OP_READ, rb_addr(0), '0, 32'd0);
      run_steps();
      end_test("readback", err_before);

      // Bootloader done pulses the bus reset once
      err_before = errors;
      add_step(OP_WRITE, set_addr(5), 32'd1, '0);
      run_steps();
      wait_bus_reset(seen);
      checks++;
      assert (seen) else begin
         $display("Bus reset never restored the registers after the bootloader write");
         errors++;
      end
      model_reset();
      check_outputs();
      add_step(OP_WRITE, set_addr(0), ($urandom & 32'h7F) | 32'h10, '0);
      add_step(OP_WRITE, set_addr(5), 32'd1, '0);
      run_steps();
      for (i = 0; i < 8; i++) begin                 // Window for a stray reset
         @(negedge wb_clk);
      end
      check_outputs();
      end_test("boot reset", err_before);

      // Nothing decodes 0x9000
      err_before = errors;
      add_step(OP_NOACK, 16'h9000, 32'h1234_5678, '0);
      run_steps();
      end_test("unmapped access", err_before);

      $display("Tests run: %0d, checks: %0d, errors: %0d", tests, checks, errors);
      if (errors == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- umtrx_ctrl_core.f
hdl/core_pkg.sv
hdl/wb_decoder.sv
hdl/settings_bus.sv
hdl/misc_regs.sv
hdl/boot_ctrl.sv
hdl/readback_mux.sv
hdl/umtrx_ctrl_core.sv
tests/tb_ctrl_core.sv
